/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module fetch_tb -o fetch_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
	exit 0
else
	exit 1
fi

/* source/fetch_pkg.sv */
/*
 * shared types for the instruction fetch front end
 *   word, line and memory tag widths
 *   cache index and tag fields
 *   memory bus command and icache controller state enums
 *   memory request / reply and fetch packet structs
 */

package fetch_pkg;

	// plain vector widths
	typedef logic [31:0] addr_t;
	typedef logic [31:0] inst_t;
	// one line is one memory transfer, two instructions
	typedef logic [63:0] line_t;
	// zero means the memory did not take the request
	typedef logic [3:0]  mem_tag_t;
	// address bits 7..3
	typedef logic [4:0]  cache_index_t;
	// address bits 15..8
	typedef logic [7:0]  cache_tag_t;

	localparam int NUM_LINES = 2 ** $bits(cache_index_t);

	typedef enum logic [1:0] {
		BUS_NONE = 2'h0,
		BUS_LOAD = 2'h1
	} mem_command_t;

	typedef enum logic [1:0] {
		CTRL_IDLE      = 2'h0,
		CTRL_REQUEST   = 2'h1,
		CTRL_WAIT_DATA = 2'h2
	} ctrl_state_t;

	typedef struct packed {
		mem_command_t command;
		addr_t        addr;
	} mem_req_t;

	typedef struct packed {
		mem_tag_t response;
		mem_tag_t tag;
		line_t    data;
	} mem_reply_t;

	typedef struct packed {
		logic  valid;
		addr_t pc;
		addr_t npc;
		inst_t inst;
	} fetch_packet_t;

endpackage

/* source/fetch_stage.sv */
/*
 * fetch stage, single lane
 *   program counter with redirect and stall
 *   instruction select out of the cache line
 *   registered fetch packet
 */

`timescale 1ns/100ps

module fetch_stage #(
	parameter fetch_pkg::addr_t RESET_PC = 32'h0
) (
	input  logic                     clock,
	input  logic                     reset,

	input  logic                     stall,
	input  logic                     redirect_valid,
	input  fetch_pkg::addr_t         redirect_pc,

	// from the icache controller
	input  logic                     hit,
	input  fetch_pkg::line_t         hit_line,
	output fetch_pkg::addr_t         fetch_addr,

	output fetch_pkg::fetch_packet_t fetch_packet
);

	fetch_pkg::addr_t pc;
	fetch_pkg::addr_t next_seq_pc;
	fetch_pkg::inst_t inst;

	assign fetch_addr  = pc;
	assign next_seq_pc = pc + 32'd4;

	// pc bit 2 picks the upper word of the line
	assign inst = pc[2] ? hit_line[63:32] : hit_line[31:0];

	//////////////////////////////////////////////////////////////
	// pc and packet register
	//////////////////////////////////////////////////////////////

	// priority is redirect, then stall, then advance on hit
	always_ff @(posedge clock) begin
		if (reset) begin
			pc                 <= RESET_PC;
			fetch_packet.valid <= 1'b0;
		end else if (redirect_valid) begin
			pc                 <= redirect_pc;
			fetch_packet.valid <= 1'b0;
		end else if (!stall) begin
			if (hit) begin
				pc                 <= next_seq_pc;
				fetch_packet.valid <= 1'b1;
				fetch_packet.pc    <= pc;
				fetch_packet.npc   <= next_seq_pc;
				fetch_packet.inst  <= inst;
			end else begin
				// miss, pc holds until the fill lands
				fetch_packet.valid <= 1'b0;
			end
		end
	end

endmodule

/* source/fetch_top.sv */
/*
 * instruction fetch front end top level
 *   fetch stage, icache controller, icache memory
 *   tagged memory bus out to the environment
 */

`timescale 1ns/100ps

module fetch_top (
	input  logic                     clock,
	input  logic                     reset,

	input  logic                     stall,
	input  logic                     redirect_valid,
	input  fetch_pkg::addr_t         redirect_pc,

	output fetch_pkg::mem_req_t      mem_req,
	input  fetch_pkg::mem_reply_t    mem_reply,

	output fetch_pkg::fetch_packet_t fetch_packet
);

	localparam fetch_pkg::addr_t RESET_PC = 32'h0;

	// fetch stage to controller
	fetch_pkg::addr_t        fetch_addr;
	logic                    hit;
	fetch_pkg::line_t        hit_line;

	// controller to cache memory
	fetch_pkg::cache_index_t rd_index;
	fetch_pkg::cache_tag_t   rd_tag;
	fetch_pkg::line_t        rd_data;
	logic                    rd_valid;
	logic                    wr_en;
	fetch_pkg::cache_index_t wr_index;
	fetch_pkg::cache_tag_t   wr_tag;

	fetch_stage #(
		.RESET_PC(RESET_PC)
	) fetch_stage_inst (
		.clock          (clock),
		.reset          (reset),
		.stall          (stall),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.hit            (hit),
		.hit_line       (hit_line),
		.fetch_addr     (fetch_addr),
		.fetch_packet   (fetch_packet)
	);

	icache_ctrl icache_ctrl_inst (
		.clock      (clock),
		.reset      (reset),
		.fetch_addr (fetch_addr),
		.hit        (hit),
		.hit_line   (hit_line),
		.mem_req    (mem_req),
		.mem_reply  (mem_reply),
		.rd_index   (rd_index),
		.rd_tag     (rd_tag),
		.rd_data    (rd_data),
		.rd_valid   (rd_valid),
		.wr_en      (wr_en),
		.wr_index   (wr_index),
		.wr_tag     (wr_tag)
	);

	// fill data comes straight from the reply
	icache_mem icache_mem_inst (
		.clock    (clock),
		.reset    (reset),
		.rd_index (rd_index),
		.rd_tag   (rd_tag),
		.rd_data  (rd_data),
		.rd_valid (rd_valid),
		.wr_en    (wr_en),
		.wr_index (wr_index),
		.wr_tag   (wr_tag),
		.wr_data  (mem_reply.data)
	);

endmodule

/* source/icache_ctrl.sv */
/*
 * instruction cache controller
 *   splits the fetch address into cache index and tag
 *   hit / miss decision for the fetch stage
 *   one outstanding line load on the tagged memory bus
 *   fill enable once the matching reply tag shows up
 */

`timescale 1ns/100ps

module icache_ctrl (
	input  logic                    clock,
	input  logic                    reset,

	// fetch stage side
	input  fetch_pkg::addr_t        fetch_addr,
	output logic                    hit,
	output fetch_pkg::line_t        hit_line,

	// memory bus
	output fetch_pkg::mem_req_t     mem_req,
	input  fetch_pkg::mem_reply_t   mem_reply,

	// cache memory lookup
	output fetch_pkg::cache_index_t rd_index,
	output fetch_pkg::cache_tag_t   rd_tag,
	input  fetch_pkg::line_t        rd_data,
	input  logic                    rd_valid,

	// cache memory fill
	output logic                    wr_en,
	output fetch_pkg::cache_index_t wr_index,
	output fetch_pkg::cache_tag_t   wr_tag
);

	fetch_pkg::ctrl_state_t state;
	fetch_pkg::ctrl_state_t next_state;
	// tag the memory handed back when it took our load
	fetch_pkg::mem_tag_t    pending_tag;
	// line aligned address of the miss being serviced
	fetch_pkg::addr_t       miss_addr;

	//////////////////////////////////////////////////////////////
	// lookup
	//////////////////////////////////////////////////////////////

	assign rd_index = fetch_addr[7:3];
	assign rd_tag   = fetch_addr[15:8];
	assign hit      = rd_valid;
	assign hit_line = rd_data;

	// fill goes to the latched miss line, not the current pc
	// so a redirect mid-miss still lands the data in the right slot
	assign wr_index = miss_addr[7:3];
	assign wr_tag   = miss_addr[15:8];

	//////////////////////////////////////////////////////////////
	// miss FSM
	//////////////////////////////////////////////////////////////

	always_comb begin
		next_state      = state;
		mem_req.command = fetch_pkg::BUS_NONE;
		mem_req.addr    = miss_addr;
		wr_en           = 1'b0;
		case (state)
			fetch_pkg::CTRL_IDLE: begin
				if (!rd_valid) begin
					next_state = fetch_pkg::CTRL_REQUEST;
				end
			end
			fetch_pkg::CTRL_REQUEST: begin
				// keep asking until memory gives a nonzero response
				mem_req.command = fetch_pkg::BUS_LOAD;
				if (mem_reply.response != '0) begin
					next_state = fetch_pkg::CTRL_WAIT_DATA;
				end
			end
			fetch_pkg::CTRL_WAIT_DATA: begin
				// foreign tags are just ignored
				if (mem_reply.tag == pending_tag) begin
					wr_en      = 1'b1;
					next_state = fetch_pkg::CTRL_IDLE;
				end
			end
			default: begin
				next_state = fetch_pkg::CTRL_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= fetch_pkg::CTRL_IDLE;
			pending_tag <= '0;
		end else begin
			state <= next_state;
			// accept cycle, remember which tag to wait for
			if (state == fetch_pkg::CTRL_REQUEST && mem_reply.response != '0) begin
				pending_tag <= mem_reply.response;
			end
		end
	end

	// miss address captured when leaving idle
	always_ff @(posedge clock) begin
		if (state == fetch_pkg::CTRL_IDLE && !rd_valid) begin
			miss_addr <= {fetch_addr[31:3], 3'b000};
		end
	end

endmodule

/* source/icache_mem.sv */
/*
 * direct mapped instruction cache storage
 *   valid bits, tag array and line array
 *   combinational tagged read, synchronous line fill
 */

`timescale 1ns/100ps

module icache_mem (
	input  logic                    clock,
	input  logic                    reset,

	// lookup side, driven from the fetch address
	input  fetch_pkg::cache_index_t rd_index,
	input  fetch_pkg::cache_tag_t   rd_tag,
	output fetch_pkg::line_t        rd_data,
	output logic                    rd_valid,

	// fill side, data comes straight off the memory bus
	input  logic                    wr_en,
	input  fetch_pkg::cache_index_t wr_index,
	input  fetch_pkg::cache_tag_t   wr_tag,
	input  fetch_pkg::line_t        wr_data
);

	logic [fetch_pkg::NUM_LINES-1:0] line_valid;
	fetch_pkg::cache_tag_t           tags  [fetch_pkg::NUM_LINES];
	fetch_pkg::line_t                lines [fetch_pkg::NUM_LINES];

	//////////////////////////////////////////////////////////////
	// read port
	//////////////////////////////////////////////////////////////

	// hit needs a valid line and a matching stored tag
	assign rd_data  = lines[rd_index];
	assign rd_valid = line_valid[rd_index] && (tags[rd_index] == rd_tag);

	//////////////////////////////////////////////////////////////
	// fill port
	//////////////////////////////////////////////////////////////

	// valid bits are control state, cleared on reset
	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
		end else if (wr_en) begin
			line_valid[wr_index] <= 1'b1;
		end
	end

	// tag and data arrays, written only on a fill
	always_ff @(posedge clock) begin
		if (wr_en) begin
			tags[wr_index]  <= wr_tag;
			lines[wr_index] <= wr_data;
		end
	end

endmodule

/* sources.f */
source/fetch_pkg.sv
source/icache_mem.sv
source/icache_ctrl.sv
source/fetch_stage.sv
source/fetch_top.sv
testbench/fetch_tb.sv

/* testbench/fetch_golden.txt */
// memory image, 32 words, word i is the instruction at byte address 4*i
// then packet count, redirect count, three (after packet, target) pairs, stall (after packet, cycles)
00100093
00200113
00308193
00410213
00518293
00620313
00728393
00830413
00938493
00a40513
00b48593
00c50613
00d58693
00e60713
00f68793
01070813
01178893
01280913
01388993
01490a13
01598a93
016a0b13
017a8b93
018b0c13
019b8c93
01ac0d13
01bc8d93
01cd0e13
01dd8e93
01ee0f13
01fe8f93
0000006f
// packet count and redirect count
00000016
00000003
// redirects: after packet, target
00000006 00000040
0000000c 00000008
00000012 00000070
// stall: after packet, cycles held
00000009 00000005

/* testbench/fetch_tb.sv */
/*
 * testbench for the instruction fetch front end
 *   clock, reset, tagged memory model with refusals and foreign tags
 *   redirect and stall schedules read from the golden file
 *   compare tasks, cycle limit and final report
 */

`timescale 1ns/100ps

module fetch_tb;

	logic                     clock;
	logic                     reset;
	logic                     stall;
	logic                     redirect_valid;
	fetch_pkg::addr_t         redirect_pc;
	fetch_pkg::mem_req_t      mem_req;
	fetch_pkg::mem_reply_t    mem_reply;
	fetch_pkg::fetch_packet_t fetch_packet;

	// golden layout is 32 image words, packet count, redirect count,
	// three (packet, target) pairs and stall (packet, cycles)
	logic [31:0]      golden [0:41];
	int               n_expected;
	int               n_redir;
	int               redir_at [3];
	fetch_pkg::addr_t redir_target [3];
	int               stall_at;
	int               stall_len;
	int               limit;
	int               cycles = 0;
	int               errors [1:6];
	int               checks;
	string            names [1:6];
	integer           seed;

	// expected fetch sequence
	fetch_pkg::addr_t         exp_pc;
	fetch_pkg::addr_t         alt_pc;
	logic [15:0]              loaded;
	logic [15:0]              loaded_snap;
	logic                     first_after;
	fetch_pkg::fetch_packet_t exp_pkt;
	fetch_pkg::fetch_packet_t held;
	int                       seen;
	int                       next_redir;
	int                       stall_left;
	int                       test;
	int                       total;

	// memory model state
	int                  mstate;
	int                  refuse_left;
	int                  delay;
	int                  refused;
	fetch_pkg::mem_tag_t next_tag;
	fetch_pkg::mem_tag_t acc_tag;
	fetch_pkg::addr_t    req_addr;

	fetch_top fetch_top_inst (
		.clock          (clock),
		.reset          (reset),
		.stall          (stall),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.mem_req        (mem_req),
		.mem_reply      (mem_reply),
		.fetch_packet   (fetch_packet)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////

	task automatic check_packet(input int t, input fetch_pkg::fetch_packet_t exp,
			input fetch_pkg::fetch_packet_t act);
		checks++;
		if (act !== exp) begin
			errors[t]++;
			// fields in order valid pc npc inst
			$display("MISMATCH %s expected %b %h %h %h actual %b %h %h %h",
				names[t], exp.valid, exp.pc, exp.npc, exp.inst,
				act.valid, act.pc, act.npc, act.inst);
		end
	endtask

	task automatic check_valid(input int t, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors[t]++;
			$display("MISMATCH %s expected valid %b actual valid %b", names[t], exp, act);
		end
	endtask

	task automatic check_addr(input int t, input fetch_pkg::addr_t exp,
			input fetch_pkg::addr_t act);
		checks++;
		if (act !== exp) begin
			errors[t]++;
			$display("MISMATCH %s expected addr %h actual addr %h", names[t], exp, act);
		end
	endtask

	task automatic check_command(input int t, input fetch_pkg::mem_command_t exp,
			input fetch_pkg::mem_command_t act);
		checks++;
		if (act !== exp) begin
			errors[t]++;
			$display("MISMATCH %s expected command %h actual command %h",
				names[t], exp, act);
		end
	endtask

	// line as memory returns it with the upper word at pc bit 2 set
	function automatic fetch_pkg::line_t image_line(input fetch_pkg::addr_t a);
		int idx;
		idx = int'(a[6:3]);
		return {golden[2 * idx + 1], golden[2 * idx]};
	endfunction

	//////////////////////////////////////////////////////////////
	// tagged memory model stepped on each falling edge
	//////////////////////////////////////////////////////////////

	task automatic mem_step();
		fetch_pkg::mem_tag_t foreign;
		fetch_pkg::addr_t    want;
		int                  li;
		// idle cycles carry a tag that never matches the pending one
		foreign = (acc_tag == 4'd15) ? 4'd1 : acc_tag + 4'd1;
		mem_reply.response = '0;
		mem_reply.tag      = foreign;
		mem_reply.data     = ~image_line(req_addr);
		if (mstate == 0 && mem_req.command == fetch_pkg::BUS_LOAD) begin
			req_addr = mem_req.addr;
			// a load may still be for the line before a redirect
			if (mem_req.addr[31:3] == alt_pc[31:3])
				want = {alt_pc[31:3], 3'b000};
			else
				want = {exp_pc[31:3], 3'b000};
			check_addr(2, want, mem_req.addr);
			li = int'(mem_req.addr[6:3]);
			if (loaded[li]) begin
				errors[5]++;
				$display("line at %h was requested again after it was filled", mem_req.addr);
			end
			loaded[li]  = 1'b1;
			refuse_left = int'($unsigned($random(seed)) % 32'd4);
			mstate      = 1;
		end else if (mstate == 1) begin
			// retry must keep the same address
			check_command(6, fetch_pkg::BUS_LOAD, mem_req.command);
			check_addr(6, req_addr, mem_req.addr);
		end else if (mstate == 2) begin
			check_command(6, fetch_pkg::BUS_NONE, mem_req.command);
			delay--;
			if (delay == 0) begin
				mem_reply.tag  = acc_tag;
				mem_reply.data = image_line(req_addr);
				mstate         = 0;
			end
		end
		if (mstate == 1) begin
			if (refuse_left == 0) begin
				mem_reply.response = next_tag;
				acc_tag            = next_tag;
				next_tag           = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
				delay              = 1 + int'($unsigned($random(seed)) % 32'd4);
				mstate             = 2;
			end else begin
				refuse_left--;
				refused++;
			end
		end
	endtask

	// run limit from the number of expected packets
	always @(posedge clock) begin
		if (!reset) begin
			cycles++;
			if (cycles > limit) begin
				$display("timeout after %0d cycles with %0d of %0d packets seen",
					cycles, seen, n_expected);
				$display("CHECKS FAILED");
				$finish;
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////

	initial begin
		reset          = 1'b1;
		stall          = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc    = '0;
		mem_reply      = '0;
		seed           = 32'he8e9_f85b;
		names[1] = "reset";
		names[2] = "sequential_fetch";
		names[3] = "redirect";
		names[4] = "stall";
		names[5] = "hits_after_fill";
		names[6] = "refusal_and_foreign_tags";
		for (int i = 1; i <= 6; i++)
			errors[i] = 0;
		checks = 0;
		$readmemh("testbench/fetch_golden.txt", golden);
		n_expected = int'(golden[32]);
		n_redir    = int'(golden[33]);
		for (int i = 0; i < 3; i++) begin
			redir_at[i]     = int'(golden[34 + 2 * i]);
			redir_target[i] = golden[35 + 2 * i];
		end
		stall_at  = int'(golden[40]);
		stall_len = int'(golden[41]);
		limit     = 40 * n_expected + 200;
		exp_pc      = '0;
		alt_pc      = '0;
		loaded      = '0;
		loaded_snap = '0;
		first_after = 1'b0;
		seen        = 0;
		next_redir  = 0;
		stall_left  = 0;
		mstate      = 0;
		refused     = 0;
		next_tag    = 4'd1;
		acc_tag     = 4'd1;
		req_addr    = '0;

		// outputs stay quiet through the 16 reset cycles
		for (int i = 0; i < 16; i++) begin
			@(negedge clock);
			if (i > 0) begin
				check_command(1, fetch_pkg::BUS_NONE, mem_req.command);
				check_valid(1, 1'b0, fetch_packet.valid);
			end
		end
		reset = 1'b0;
		$display("test %s done, %0d errors", names[1], errors[1]);

		while (seen < n_expected) begin
			@(negedge clock);
			redirect_valid = 1'b0;
			mem_step();
			if (stall_left > 0) begin
				// packet frozen while stalled
				check_packet(4, held, fetch_packet);
				stall_left--;
				if (stall_left == 0)
					stall = 1'b0;
			end else if (fetch_packet.valid) begin
				exp_pkt.valid = 1'b1;
				exp_pkt.pc    = exp_pc;
				exp_pkt.npc   = exp_pc + 32'd4;
				exp_pkt.inst  = golden[int'(exp_pc[6:2])];
				if (loaded_snap[int'(exp_pc[6:3])])
					test = 5;
				else if (first_after)
					test = 3;
				else
					test = 2;
				check_packet(test, exp_pkt, fetch_packet);
				first_after = 1'b0;
				seen++;
				exp_pc = exp_pc + 32'd4;
				if (next_redir < n_redir && seen == redir_at[next_redir]) begin
					redirect_valid = 1'b1;
					redirect_pc    = redir_target[next_redir];
					alt_pc         = exp_pc;
					exp_pc         = redir_target[next_redir];
					loaded_snap    = loaded;
					first_after    = 1'b1;
					next_redir++;
				end else if (seen == stall_at) begin
					stall      = 1'b1;
					held       = fetch_packet;
					stall_left = stall_len;
				end
			end
		end

		if (refused == 0) begin
			errors[6]++;
			$display("memory model never refused a request");
		end
		for (int i = 2; i <= 6; i++)
			$display("test %s done, %0d errors", names[i], errors[i]);
		total = 0;
		for (int i = 1; i <= 6; i++)
			total += errors[i];
		$display("6 tests, %0d checks, %0d errors, %0d packets, %0d refusals",
			checks, total, seen, refused);
		if (total == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
